//--- design/axi_sram_pkg.sv
// shared widths and encodings for the banked SRAM
// transfers are always 4 bytes, so no size field is carried
package axi_sram_pkg;

	// top-level byte address
	localparam int ADDR_W = 32;

	// data path and byte lanes
	localparam int DATA_W = 32;
	localparam int STRB_W = 4;

	// burst length field, beats = len + 1
	localparam int LEN_W = 8;

	// AXI burst type encoding
	typedef enum logic [1:0] {
		BURST_FIXED = 2'b00,
		BURST_INCR  = 2'b01,
		// not supported, answered with SLVERR
		BURST_WRAP  = 2'b10
	} burst_e;

	// AXI response encoding, only the two codes in use
	typedef enum logic [1:0] {
		RESP_OKAY   = 2'b00,
		RESP_SLVERR = 2'b10
	} resp_e;

	// router ownership of the single outstanding transaction
	typedef enum logic [1:0] {
		// free to accept AR or AW/W
		ROUTE_IDLE = 2'b00,
		// read burst in flight
		ROUTE_RD   = 2'b01,
		// single write in flight
		ROUTE_WR   = 2'b10
	} route_state_e;

endpackage

//--- design/bank_rd_if.sv
// read channel between router, one bank and the merger
// word_addr is the in-bank word index, already stripped of bank bits
interface bank_rd_if #(
	parameter int BANK_WORDS = 64
);

	localparam int WORD_W = $clog2(BANK_WORDS);

	// request side, router to bank
	logic                           arvalid;
	logic                           arready;
	logic [WORD_W-1:0]              word_addr;
	logic [axi_sram_pkg::LEN_W-1:0] arlen;
	axi_sram_pkg::burst_e           arburst;

	// beat side, bank to merger
	logic                            rvalid;
	logic [axi_sram_pkg::DATA_W-1:0] rdata;
	axi_sram_pkg::resp_e             rresp;
	logic                            rlast;
	logic                            rready;

	modport router (
		output arvalid, word_addr, arlen, arburst,
		input  arready
	);

	modport bank (
		input  arvalid, word_addr, arlen, arburst, rready,
		output arready, rvalid, rdata, rresp, rlast
	);

	// merger only sees the beat and hands back rready
	modport merger (
		input  rvalid, rdata, rresp, rlast,
		output rready
	);

endinterface

//--- design/bank_wr_if.sv
// write channel between router, one bank and the merger
// single-beat writes only, address and data arrive together
interface bank_wr_if #(
	parameter int BANK_WORDS = 64
);

	localparam int WORD_W = $clog2(BANK_WORDS);

	// combined AW/W request
	logic                            wvalid;
	logic                            wready;
	logic [WORD_W-1:0]               word_addr;
	logic [axi_sram_pkg::DATA_W-1:0] wdata;
	logic [axi_sram_pkg::STRB_W-1:0] wstrb;

	// write response
	logic                bvalid;
	axi_sram_pkg::resp_e bresp;
	logic                bready;

	modport router (output wvalid, word_addr, wdata, wstrb, input wready);

	modport bank (
		input  wvalid, word_addr, wdata, wstrb, bready,
		output wready, bvalid, bresp
	);

	modport merger (input bvalid, bresp, output bready);

endinterface

//--- design/txn_router.sv
// decodes bank from the word address and keeps one transaction outstanding
// NUM_BANKS must be 2 or more, upper address bits alias
module txn_router #(
	parameter int NUM_BANKS  = 4,
	parameter int BANK_WORDS = 64
) (
	input  logic                            clk,
	input  logic                            rst,
	input  logic [axi_sram_pkg::ADDR_W-1:0] araddr,
	input  logic [axi_sram_pkg::LEN_W-1:0]  arlen,
	input  logic [1:0]                      arburst,
	input  logic                            arvalid,
	output logic                            arready,
	input  logic [axi_sram_pkg::ADDR_W-1:0] awaddr,
	input  logic [axi_sram_pkg::DATA_W-1:0] wdata,
	input  logic [axi_sram_pkg::STRB_W-1:0] wstrb,
	input  logic                            awvalid,
	input  logic                            wvalid,
	output logic                            awready,
	output logic                            wready,
	input  logic                            txn_done,
	output axi_sram_pkg::route_state_e      route_state,
	output logic [$clog2(NUM_BANKS)-1:0]    sel_bank,
	bank_rd_if.router                       rd [NUM_BANKS],
	bank_wr_if.router                       wr [NUM_BANKS]
);

	localparam int WORD_W = $clog2(BANK_WORDS);
	localparam int BANK_W = $clog2(NUM_BANKS);

	logic [BANK_W-1:0]    ar_bank;
	logic [BANK_W-1:0]    aw_bank;
	logic [NUM_BANKS-1:0] bank_arready;
	logic [NUM_BANKS-1:0] bank_wready;
	logic                 live;
	logic                 open;
	logic                 wr_offer;

	// byte offset in [1:0], word index next, bank bits right above
	assign ar_bank = araddr[2 + WORD_W +: BANK_W];
	assign aw_bank = awaddr[2 + WORD_W +: BANK_W];

	// live stays low through reset so no ready leaks out early
	always_ff @(posedge clk) begin
		if (rst) begin
			live <= 1'b0;
		end else begin
			live <= 1'b1;
		end
	end

	assign open = live && (route_state == axi_sram_pkg::ROUTE_IDLE);

	// AR wins a tie, write waits for a cycle with no arvalid
	assign wr_offer = open && !arvalid && awvalid && wvalid;
	assign arready  = open && bank_arready[ar_bank];
	assign awready  = wr_offer && bank_wready[aw_bank];
	// AW and W move as a pair
	assign wready   = awready;

	for (genvar i = 0; i < NUM_BANKS; i++) begin : g_fwd
		assign bank_arready[i] = rd[i].arready;
		// valid reaches the decoded bank only
		assign rd[i].arvalid   = arvalid && open && (ar_bank == BANK_W'(i));
		assign rd[i].word_addr = araddr[2 +: WORD_W];
		assign rd[i].arlen     = arlen;
		assign rd[i].arburst   = axi_sram_pkg::burst_e'(arburst);

		assign bank_wready[i]  = wr[i].wready;
		assign wr[i].wvalid    = wr_offer && (aw_bank == BANK_W'(i));
		assign wr[i].word_addr = awaddr[2 +: WORD_W];
		assign wr[i].wdata     = wdata;
		assign wr[i].wstrb     = wstrb;
	end

	// owner held from acceptance until the merger reports completion
	always_ff @(posedge clk) begin
		if (rst) begin
			route_state <= axi_sram_pkg::ROUTE_IDLE;
			sel_bank    <= '0;
		end else begin
			case (route_state)
				axi_sram_pkg::ROUTE_IDLE: begin
					if (arvalid && arready) begin
						route_state <= axi_sram_pkg::ROUTE_RD;
						sel_bank    <= ar_bank;
					end else if (awready) begin
						route_state <= axi_sram_pkg::ROUTE_WR;
						sel_bank    <= aw_bank;
					end
				end
				axi_sram_pkg::ROUTE_RD, axi_sram_pkg::ROUTE_WR: begin
					// back to idle the cycle after the done pulse
					if (txn_done) begin
						route_state <= axi_sram_pkg::ROUTE_IDLE;
					end
				end
				default: route_state <= axi_sram_pkg::ROUTE_IDLE;
			endcase
		end
	end

endmodule

//--- design/sram_bank.sv
// one bank: burst read FSM, single-beat write, flop array with no init
// WRAP, reserved bursts and beats past the last word return SLVERR, zero data
module sram_bank #(
	parameter int NUM_BANKS  = 4,
	parameter int BANK_WORDS = 64
) (
	input  logic    clk,
	input  logic    rst,
	bank_rd_if.bank rd,
	bank_wr_if.bank wr
);

	localparam int WORD_W = $clog2(BANK_WORDS);
	// running index covers the whole map times the longest burst,
	// so an INCR burst never wraps back onto a valid word
	localparam int IDX_W  = $clog2(NUM_BANKS * BANK_WORDS) + axi_sram_pkg::LEN_W;

	typedef enum logic [1:0] {
		RD_IDLE = 2'b00,
		RD_BEAT = 2'b01,
		RD_LAST = 2'b10
	} rd_state_e;

	rd_state_e rd_state;

	logic [axi_sram_pkg::DATA_W-1:0] mem [BANK_WORDS];

	// captured burst
	logic [IDX_W-1:0]               idx;
	logic [axi_sram_pkg::LEN_W-1:0] len_q;
	logic [axi_sram_pkg::LEN_W-1:0] beat_cnt;
	axi_sram_pkg::burst_e           burst_q;

	logic ar_fire;
	logic r_fire;
	logic w_fire;
	logic beat_err;
	logic bvalid_q;

	// read side

	assign rd.arready = (rd_state == RD_IDLE);
	assign ar_fire    = rd.arvalid && rd.arready;

	// beat visible in every non-idle state
	assign rd.rvalid = (rd_state != RD_IDLE);
	// RD_LAST is entered exactly when beat_cnt reaches len_q
	assign rd.rlast  = (rd_state == RD_LAST);
	assign r_fire    = rd.rvalid && rd.rready;

	// only FIXED and INCR are served
	assign beat_err = ((burst_q != axi_sram_pkg::BURST_FIXED) &&
		(burst_q != axi_sram_pkg::BURST_INCR)) ||
		(idx > IDX_W'(BANK_WORDS - 1));

	assign rd.rresp = beat_err ? axi_sram_pkg::RESP_SLVERR : axi_sram_pkg::RESP_OKAY;
	// async read at the current index
	assign rd.rdata = beat_err ? '0 : mem[idx[WORD_W-1:0]];

	always_ff @(posedge clk) begin
		if (rst) begin
			rd_state <= RD_IDLE;
		end else begin
			case (rd_state)
				RD_IDLE: begin
					// single-beat burst goes straight to the last beat
					if (ar_fire) begin
						rd_state <= (rd.arlen == '0) ? RD_LAST : RD_BEAT;
					end
				end
				RD_BEAT: begin
					if (r_fire && (beat_cnt + 1'b1 == len_q)) begin
						rd_state <= RD_LAST;
					end
				end
				RD_LAST: begin
					if (r_fire) begin
						rd_state <= RD_IDLE;
					end
				end
				default: rd_state <= RD_IDLE;
			endcase
		end
	end

	// index and count only move on a transfer, so a stalled beat holds
	always_ff @(posedge clk) begin
		if (ar_fire) begin
			idx      <= IDX_W'(rd.word_addr);
			len_q    <= rd.arlen;
			burst_q  <= rd.arburst;
			beat_cnt <= '0;
		end else if (r_fire) begin
			beat_cnt <= beat_cnt + 1'b1;
			// FIXED keeps pointing at the same word
			if (burst_q == axi_sram_pkg::BURST_INCR) begin
				idx <= idx + 1'b1;
			end
		end
	end

	// write side

	// no write while a read is running or a response is unclaimed
	assign wr.wready = (rd_state == RD_IDLE) && !bvalid_q;
	assign w_fire    = wr.wvalid && wr.wready;
	assign wr.bvalid = bvalid_q;
	assign wr.bresp  = axi_sram_pkg::RESP_OKAY;

	always_ff @(posedge clk) begin
		if (rst) begin
			bvalid_q <= 1'b0;
		end else if (w_fire) begin
			bvalid_q <= 1'b1;
		end else if (wr.bready) begin
			bvalid_q <= 1'b0;
		end
	end

	// byte-lane merge under wstrb
	always_ff @(posedge clk) begin
		if (w_fire) begin
			for (int b = 0; b < axi_sram_pkg::STRB_W; b++) begin
				if (wr.wstrb[b]) begin
					mem[wr.word_addr][8*b +: 8] <= wr.wdata[8*b +: 8];
				end
			end
		end
	end

endmodule

//--- design/resp_merger.sv
// muxes the owning bank's R or B beat onto the top-level port
// txn_done is registered, one cycle after the closing transfer
module resp_merger #(
	parameter int NUM_BANKS = 4
) (
	input  logic                            clk,
	input  logic                            rst,
	input  axi_sram_pkg::route_state_e      route_state,
	input  logic [$clog2(NUM_BANKS)-1:0]    sel_bank,
	bank_rd_if.merger                       rd [NUM_BANKS],
	bank_wr_if.merger                       wr [NUM_BANKS],
	output logic [axi_sram_pkg::DATA_W-1:0] rdata,
	output logic [1:0]                      rresp,
	output logic                            rlast,
	output logic                            rvalid,
	input  logic                            rready,
	output logic [1:0]                      bresp,
	output logic                            bvalid,
	input  logic                            bready,
	output logic                            txn_done
);

	localparam int BANK_W = $clog2(NUM_BANKS);

	// per-bank beats flattened for a variable index
	logic [NUM_BANKS-1:0]            rv;
	logic [NUM_BANKS-1:0]            rl;
	logic [NUM_BANKS-1:0]            bv;
	logic [axi_sram_pkg::DATA_W-1:0] rd_v [NUM_BANKS];
	axi_sram_pkg::resp_e             rr_v [NUM_BANKS];
	axi_sram_pkg::resp_e             br_v [NUM_BANKS];
	logic                            rd_own;
	logic                            wr_own;

	assign rd_own = (route_state == axi_sram_pkg::ROUTE_RD);
	assign wr_own = (route_state == axi_sram_pkg::ROUTE_WR);

	for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
		assign rv[i]   = rd[i].rvalid;
		assign rl[i]   = rd[i].rlast;
		assign rd_v[i] = rd[i].rdata;
		assign rr_v[i] = rd[i].rresp;
		assign bv[i]   = wr[i].bvalid;
		assign br_v[i] = wr[i].bresp;
		// ready goes back to the owning bank only
		assign rd[i].rready = rd_own && (sel_bank == BANK_W'(i)) && rready;
		assign wr[i].bready = wr_own && (sel_bank == BANK_W'(i)) && bready;
	end

	// valids forced low whenever the channel is not owned
	assign rvalid = rd_own && rv[sel_bank];
	assign rlast  = rd_own && rl[sel_bank];
	assign rdata  = rd_v[sel_bank];
	assign rresp  = rr_v[sel_bank];
	assign bvalid = wr_own && bv[sel_bank];
	assign bresp  = br_v[sel_bank];

	// last R or the B closes the transaction
	always_ff @(posedge clk) begin
		if (rst) begin
			txn_done <= 1'b0;
		end else begin
			txn_done <= (rvalid && rready && rlast) || (bvalid && bready);
		end
	end

endmodule

//--- design/axi_sram_top.sv
// banked SRAM with an AXI4-style slave, one transaction at a time
// 4-byte transfers, single-beat writes, NUM_BANKS and BANK_WORDS powers of two
module axi_sram_top #(
	parameter int NUM_BANKS  = 4,
	parameter int BANK_WORDS = 64
) (
	input  logic                            clk,
	input  logic                            rst,
	// read address
	input  logic [axi_sram_pkg::ADDR_W-1:0] araddr,
	input  logic [axi_sram_pkg::LEN_W-1:0]  arlen,
	input  logic [1:0]                      arburst,
	input  logic                            arvalid,
	output logic                            arready,
	// read data
	output logic [axi_sram_pkg::DATA_W-1:0] rdata,
	output logic [1:0]                      rresp,
	output logic                            rlast,
	output logic                            rvalid,
	input  logic                            rready,
	// write address, data and response
	input  logic [axi_sram_pkg::ADDR_W-1:0] awaddr,
	input  logic [axi_sram_pkg::DATA_W-1:0] wdata,
	input  logic [axi_sram_pkg::STRB_W-1:0] wstrb,
	input  logic                            awvalid,
	input  logic                            wvalid,
	output logic                            awready,
	output logic                            wready,
	output logic [1:0]                      bresp,
	output logic                            bvalid,
	input  logic                            bready
);

	axi_sram_pkg::route_state_e       route_state;
	logic [$clog2(NUM_BANKS)-1:0]     sel_bank;
	logic                             txn_done;

	// one read and one write channel per bank
	bank_rd_if #(.BANK_WORDS(BANK_WORDS)) rd_if [NUM_BANKS] ();
	bank_wr_if #(.BANK_WORDS(BANK_WORDS)) wr_if [NUM_BANKS] ();

	txn_router #(
		.NUM_BANKS  (NUM_BANKS),
		.BANK_WORDS (BANK_WORDS)
	) u_router (
		.clk, .rst,
		.araddr, .arlen, .arburst, .arvalid, .arready,
		.awaddr, .wdata, .wstrb, .awvalid, .wvalid, .awready, .wready,
		.txn_done,
		.route_state,
		.sel_bank,
		.rd (rd_if),
		.wr (wr_if)
	);

	for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
		sram_bank #(
			.NUM_BANKS  (NUM_BANKS),
			.BANK_WORDS (BANK_WORDS)
		) u_bank (
			.clk,
			.rst,
			.rd  (rd_if[i]),
			.wr  (wr_if[i])
		);
	end

	resp_merger #(
		.NUM_BANKS (NUM_BANKS)
	) u_merger (
		.clk, .rst,
		.route_state,
		.sel_bank,
		.rd (rd_if),
		.wr (wr_if),
		.rdata, .rresp, .rlast, .rvalid, .rready,
		.bresp, .bvalid, .bready,
		.txn_done
	);

endmodule

//--- dv/tb_axi_sram.sv
// replays dv/stimulus_axi_sram.txt against the DUT with random rready/bready
// assumes default parameters: 4 banks of 64 words, bank bits at addr[9:8]
module tb_axi_sram;

	logic        clk = 1'b0;
	logic        rst;
	logic [31:0] araddr;
	logic [7:0]  arlen;
	logic [1:0]  arburst;
	logic        arvalid;
	logic        arready;
	logic [31:0] rdata;
	logic [1:0]  rresp;
	logic        rlast;
	logic        rvalid;
	logic        rready = 1'b0;
	logic [31:0] awaddr;
	logic [31:0] wdata;
	logic [3:0]  wstrb;
	logic        awvalid;
	logic        wvalid;
	logic        awready;
	logic        wready;
	logic [1:0]  bresp;
	logic        bvalid;
	logic        bready = 1'b0;

	// parsed file, one entry per command or expected beat
	logic [7:0]  cmd_q [$];
	logic [31:0] f1_q [$];
	logic [31:0] f2_q [$];
	logic [31:0] f3_q [$];
	logic [31:0] f4_q [$];

	integer seed = 32'ha97c;
	integer cycles = 0;
	integer limit = 0;
	integer cmds = 0;
	integer exp_beats = 0;
	integer got_beats = 0;

	axi_sram_top uut (
		.clk, .rst,
		.araddr, .arlen, .arburst, .arvalid, .arready,
		.rdata, .rresp, .rlast, .rvalid, .rready,
		.awaddr, .wdata, .wstrb, .awvalid, .wvalid, .awready, .wready,
		.bresp, .bvalid, .bready
	);

	always #5 clk = ~clk;

	// back-pressure, ready high about 70% of cycles
	always @(posedge clk) begin
		#1;
		rready = ((($random(seed) & 32'h7fffffff) % 10) < 7);
		bready = ((($random(seed) & 32'h7fffffff) % 10) < 7);
	end

	// every R transfer on the port, seen apart from the read task
	always @(negedge clk) begin
		if (!rst && rvalid && rready) begin
			got_beats <= got_beats + 1;
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles > limit) begin
			$display("Timeout: run did not finish within %0d cycles", limit);
			$display("SIMULATION FAILED");
			$fatal(1);
		end
	end

	task automatic check_val(input string name, input logic [31:0] want, input logic [31:0] got);
		assert (got === want) else begin
			$display("Mismatch %s exp=%h got=%h", name, want, got);
			$display("SIMULATION FAILED");
			$fatal(1);
		end
	endtask

	task automatic check_true(input logic ok, input string what);
		assert (ok === 1'b1) else begin
			$display("%s", what);
			$display("SIMULATION FAILED");
			$fatal(1);
		end
	endtask

	// '#' lines are comments, every other line is a command or an E beat
	task automatic load_file();
		integer     fd;
		integer     n;
		string      line;
		logic [7:0] c;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] d;
		logic [31:0] e;
		fd = $fopen("dv/stimulus_axi_sram.txt", "r");
		check_true(fd != 0, "cannot open the stimulus file dv/stimulus_axi_sram.txt");
		while (!$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			if (n > 1 && line[0] != "#") begin
				e = '0;
				n = $sscanf(line, "%c %h %h %h %h", c, a, b, d, e);
				cmd_q.push_back(c);
				f1_q.push_back(a);
				f2_q.push_back(b);
				f3_q.push_back(d);
				f4_q.push_back(e);
				if (c == "E") begin
					exp_beats = exp_beats + 1;
				end else begin
					cmds = cmds + 1;
				end
			end
		end
		$fclose(fd);
	endtask

	// awvalid/wvalid already high; waits for the handshake, then takes the B beat
	task automatic finish_write();
		logic accepted;
		logic first;
		logic done;
		accepted = 1'b0;
		while (!accepted) begin
			@(negedge clk);
			check_val("wready", 32'(awready), 32'(wready));
			accepted = awready;
			@(posedge clk);
			#1;
		end
		awvalid = 1'b0;
		wvalid  = 1'b0;
		first = 1'b1;
		done  = 1'b0;
		// bvalid must show in the very next cycle and hold until bready
		while (!done) begin
			@(negedge clk);
			check_true(bvalid, first ? "bvalid not one cycle after the write handshake"
				: "bvalid dropped before bready");
			check_val("bresp", 32'h0, 32'(bresp));
			first = 1'b0;
			done  = bready;
			@(posedge clk);
			#1;
		end
		@(negedge clk);
		check_true(!bvalid, "second write response after the B transfer");
		@(posedge clk);
		#1;
	endtask

	// R line at index at, its E lines follow; pair keeps a write waiting
	task automatic do_read(input int at, input logic pair);
		int          n;
		int          k;
		logic        accepted;
		logic        first;
		logic        stalled;
		logic [31:0] held_data;
		logic [1:0]  held_resp;
		logic        held_last;
		n = int'(f2_q[at]) + 1;
		araddr  = f1_q[at];
		arlen   = f2_q[at][7:0];
		arburst = f3_q[at][1:0];
		arvalid = 1'b1;
		accepted = 1'b0;
		while (!accepted) begin
			@(negedge clk);
			if (pair) check_true(!awready, "write accepted in the same cycle as a read");
			accepted = arready;
			@(posedge clk);
			#1;
		end
		arvalid = 1'b0;
		k = 0;
		first = 1'b1;
		stalled = 1'b0;
		while (k < n) begin
			@(negedge clk);
			check_true(rvalid, first ? "rvalid not one cycle after the AR handshake"
				: "rvalid dropped inside a burst");
			if (pair) check_true(!awready, "write accepted before the read burst ended");
			// a stalled beat must not change
			if (stalled) begin
				check_val("rdata", held_data, rdata);
				check_val("rresp", 32'(held_resp), 32'(rresp));
				check_val("rlast", 32'(held_last), 32'(rlast));
			end
			if (rready) begin
				check_val("rdata", f1_q[at + 1 + k], rdata);
				check_val("rresp", f2_q[at + 1 + k], 32'(rresp));
				check_val("rlast", f3_q[at + 1 + k], 32'(rlast));
				k = k + 1;
				stalled = 1'b0;
			end else begin
				stalled   = 1'b1;
				held_data = rdata;
				held_resp = rresp;
				held_last = rlast;
			end
			first = 1'b0;
			@(posedge clk);
			#1;
		end
		@(negedge clk);
		check_true(!rvalid, "extra read beat after rlast");
		@(posedge clk);
		#1;
	endtask

	initial begin
		int          pos;
		logic        pair_pend;
		araddr  = '0;
		arlen   = '0;
		arburst = '0;
		arvalid = 1'b0;
		awaddr  = '0;
		wdata   = '0;
		wstrb   = '0;
		// write offered through reset, no ready may answer it
		awvalid = 1'b1;
		wvalid  = 1'b1;
		rst     = 1'b1;
		pair_pend = 1'b0;
		load_file();
		limit = 20 * (cmds + exp_beats) + 100;

		// no ready may leak out while reset is held
		repeat (15) begin
			@(posedge clk);
			@(negedge clk);
			check_true(!arready && !awready && !wready, "ready high during reset");
		end
		@(posedge clk);
		#1;
		rst     = 1'b0;
		awvalid = 1'b0;
		wvalid  = 1'b0;

		// idle bus, nothing may come back
		repeat (4) begin
			@(negedge clk);
			check_true(!rvalid && !bvalid, "response valid with no request after reset");
			@(posedge clk);
			#1;
		end

		pos = 0;
		while (pos < cmd_q.size()) begin
			case (cmd_q[pos])
				"W": begin
					awaddr = f1_q[pos];
					wdata  = f2_q[pos];
					wstrb  = f3_q[pos][3:0];
					// paired write is raised together with the next AR
					if (f4_q[pos][0]) begin
						pair_pend = 1'b1;
					end else begin
						awvalid = 1'b1;
						wvalid  = 1'b1;
						finish_write();
					end
					pos = pos + 1;
				end
				"R": begin
					if (pair_pend) begin
						awvalid = 1'b1;
						wvalid  = 1'b1;
					end
					do_read(pos, pair_pend);
					if (pair_pend) begin
						finish_write();
						pair_pend = 1'b0;
					end
					pos = pos + int'(f2_q[pos]) + 2;
				end
				default: check_true(1'b0, "unexpected line in the stimulus file");
			endcase
		end

		if (got_beats == exp_beats) begin
			$display("SIMULATION PASSED");
			$finish;
		end else begin
			$display("Mismatch got_beats exp=%h got=%h", exp_beats, got_beats);
			$display("SIMULATION FAILED");
			$fatal(1);
		end
	end

endmodule

//--- dv/stimulus_axi_sram.txt
# W addr data strb pair : pair=1 holds the write back to go with the next R
# R addr len burst, then len+1 lines of E rdata rresp rlast, all hex
# bank 0, four words then an INCR read
W 00000000 11111111 f 0
W 00000004 22222222 f 0
W 00000008 33333333 f 0
W 0000000c 44444444 f 0
R 00000000 03 1
E 11111111 0 0
E 22222222 0 0
E 33333333 0 0
E 44444444 0 1
# bank 1 word 5, byte lanes merged over a full word
W 00000114 a1b2c3d4 f 0
W 00000114 000000ee 1 0
W 00000114 55660000 c 0
R 00000114 00 1
E 5566c3ee 0 1
# bank 2 word 10, FIXED burst repeats it
W 00000228 cafef00d f 0
R 00000228 02 0
E cafef00d 0 0
E cafef00d 0 0
E cafef00d 0 1
# bank 3 last two words, INCR runs off the end
W 000003f8 0badbeef f 0
W 000003fc 12345678 f 0
R 000003f8 03 1
E 0badbeef 0 0
E 12345678 0 0
E 00000000 2 0
E 00000000 2 1
# WRAP is refused on every beat
R 00000100 01 2
E 00000000 2 0
E 00000000 2 1
# write presented with a read, the read goes first
W 00000204 deadc0de f 1
R 00000228 00 1
E cafef00d 0 1
R 00000204 00 1
E deadc0de 0 1
# upper address bits alias onto bank 0
R 00001004 01 1
E 22222222 0 0
E 33333333 0 1

//--- flist.f
design/axi_sram_pkg.sv
design/bank_rd_if.sv
design/bank_wr_if.sv
design/txn_router.sv
design/sram_bank.sv
design/resp_merger.sv
design/axi_sram_top.sv
dv/tb_axi_sram.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the AXI SRAM testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log
verilator --binary -f flist.f --top-module tb_axi_sram -o sim_axi_sram
./obj_dir/sim_axi_sram | tee sim.log
if grep -q "SIMULATION FAILED" sim.log; then
	exit 1
fi
exit 0
